// File: soc_pkg.sv
package soc_pkg;

    typedef logic [31 : 0]  addr_t;         // byte address
    typedef logic [31 : 0]  data_t;         // bus data word
    typedef logic [1  : 0]  size_t;         // core access size, 0 byte 1 half 2 word
    typedef logic [2  : 0]  hsize_t;        // AHB HSIZE
    typedef logic [1  : 0]  htrans_t;       // AHB HTRANS
    typedef logic [1  : 0]  slv_sel_t;      // slave index from address

    // only single transfers, so two HTRANS codes are enough
    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;

    localparam hsize_t  HSIZE_BYTE    = 3'b000;    // 8 bit transfer
    localparam hsize_t  HSIZE_HALF    = 3'b001;    // 16 bit transfer
    localparam hsize_t  HSIZE_WORD    = 3'b010;    // 32 bit transfer

    typedef enum logic [1 : 0] {
        IDLE = 2'b00,                       // waiting for core request
        ADDR = 2'b01,                       // AHB address phase
        DATA = 2'b10                        // AHB data phase, wait hready
    } bridge_state_t;

    // address map, bits 17..16 pick the slave
    localparam int      SLV_SEL_LSB   = 16;
    localparam int      SLV_SEL_MSB   = 17;

    localparam slv_sel_t SLV_RAM      = 2'd0;  // word RAM
    localparam slv_sel_t SLV_GPIO     = 2'd1;  // GPIO registers
    localparam slv_sel_t SLV_PWM      = 2'd2;  // PWM registers
    // select value 3 is unmapped, reads zero

    // register offsets inside a slave window
    localparam logic [3 : 0] GPIO_GPI_OFS = 4'h0;  // input value, read only
    localparam logic [3 : 0] GPIO_GPO_OFS = 4'h4;  // output register
    localparam logic [3 : 0] GPIO_GPD_OFS = 4'h8;  // direction register
    localparam logic [3 : 0] PWM_DUTY_OFS = 4'h0;  // duty register

endpackage : soc_pkg

// File: ahb_if.sv
`timescale 1ns/1ps

interface ahb_if;

    soc_pkg::addr_t     haddr;      // transfer address
    soc_pkg::data_t     hwdata;     // write data, data phase
    logic               hwrite;     // 1 write, 0 read
    soc_pkg::htrans_t   htrans;     // transfer type
    soc_pkg::hsize_t    hsize;      // transfer size
    logic               hsel;       // slave select
    soc_pkg::data_t     hrdata;     // read data, data phase
    logic               hready;     // transfer done / slave ready

    modport master (
        output  haddr, hwdata, hwrite, htrans, hsize, hsel,
        input   hrdata, hready
    );

    modport slave (
        input   haddr, hwdata, hwrite, htrans, hsize, hsel,
        output  hrdata, hready
    );

endinterface : ahb_if

// File: ahb_core_bridge.sv
`timescale 1ns/1ps

module ahb_core_bridge (
    input  logic                clk,        // system clock
    input  logic                rst_n_i,    // sync reset, active low
    input  soc_pkg::addr_t      addr_i,     // core address
    input  soc_pkg::data_t      wd_i,       // core write data
    input  logic                we_i,       // core write enable
    input  soc_pkg::size_t      size_i,     // core access size
    input  logic                req_i,      // core request
    output logic                req_ack_o,  // one cycle acknowledge
    output soc_pkg::data_t      rd_o,       // read data, valid with ack
    ahb_if.master               bus         // AHB master side
);

    soc_pkg::bridge_state_t state;          // current FSM state
    soc_pkg::bridge_state_t state_nxt;      // next FSM state
    soc_pkg::addr_t         addr_r;         // captured address
    soc_pkg::data_t         wd_r;           // write data held for data phase
    logic                   we_r;           // captured write flag
    soc_pkg::hsize_t        hsize_r;        // captured transfer size

    function automatic soc_pkg::hsize_t size_to_hsize(input soc_pkg::size_t size);
        case (size)
            2'd0:    return soc_pkg::HSIZE_BYTE;
            2'd1:    return soc_pkg::HSIZE_HALF;
            default: return soc_pkg::HSIZE_WORD;   // code 3 treated as word
        endcase
    endfunction

    always_comb begin
        state_nxt = state;
        case (state)
            soc_pkg::IDLE: if (req_i)      state_nxt = soc_pkg::ADDR;
            soc_pkg::ADDR: if (bus.hready) state_nxt = soc_pkg::DATA;  // bus free, phase taken
            soc_pkg::DATA: if (bus.hready) state_nxt = soc_pkg::IDLE;  // slave done
            default:                       state_nxt = soc_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i)
            state <= soc_pkg::IDLE;
        else
            state <= state_nxt;
    end

    // request payload, taken once when leaving IDLE
    always_ff @(posedge clk) begin
        if ((state == soc_pkg::IDLE) && req_i) begin
            addr_r  <= addr_i;
            wd_r    <= wd_i;
            we_r    <= we_i;
            hsize_r <= size_to_hsize(size_i);
        end
    end

    assign bus.haddr  = addr_r;
    assign bus.hwrite = we_r;
    assign bus.hsize  = hsize_r;
    assign bus.hwdata = wd_r;                               // only sampled in DATA
    assign bus.hsel   = (state == soc_pkg::ADDR);
    assign bus.htrans = (state == soc_pkg::ADDR) ? soc_pkg::HTRANS_NONSEQ
                                                 : soc_pkg::HTRANS_IDLE;

    assign req_ack_o  = (state == soc_pkg::DATA) && bus.hready;
    assign rd_o       = bus.hrdata;                         // decoder returns zero when unmapped

    // core keeps the request and its qualifiers steady until the ack
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        (state != soc_pkg::IDLE) |-> req_i && $stable({addr_i, wd_i, we_i, size_i}));

endmodule : ahb_core_bridge

// File: ahb_decoder.sv
`timescale 1ns/1ps

module ahb_decoder (
    input  logic        clk,        // system clock
    input  logic        rst_n_i,    // sync reset, active low
    ahb_if.slave        bus,        // from bridge
    ahb_if.master       ram,        // to RAM slave
    ahb_if.master       gpio,       // to GPIO slave
    ahb_if.master       pwm         // to PWM slave
);

    soc_pkg::slv_sel_t  sel;        // address phase slave index
    soc_pkg::slv_sel_t  sel_dp;     // data phase slave index
    logic               addr_ph;    // valid address phase this cycle

    assign sel     = bus.haddr[soc_pkg::SLV_SEL_MSB : soc_pkg::SLV_SEL_LSB];
    assign addr_ph = bus.hsel && (bus.htrans == soc_pkg::HTRANS_NONSEQ) && bus.hready;

    // shared master signals go to every slave
    assign ram.haddr   = bus.haddr;
    assign ram.hwdata  = bus.hwdata;
    assign ram.hwrite  = bus.hwrite;
    assign ram.htrans  = bus.htrans;
    assign ram.hsize   = bus.hsize;
    assign gpio.haddr  = bus.haddr;
    assign gpio.hwdata = bus.hwdata;
    assign gpio.hwrite = bus.hwrite;
    assign gpio.htrans = bus.htrans;
    assign gpio.hsize  = bus.hsize;
    assign pwm.haddr   = bus.haddr;
    assign pwm.hwdata  = bus.hwdata;
    assign pwm.hwrite  = bus.hwrite;
    assign pwm.htrans  = bus.htrans;
    assign pwm.hsize   = bus.hsize;

    assign ram.hsel    = bus.hsel && (sel == soc_pkg::SLV_RAM);
    assign gpio.hsel   = bus.hsel && (sel == soc_pkg::SLV_GPIO);
    assign pwm.hsel    = bus.hsel && (sel == soc_pkg::SLV_PWM);

    // remember who owns the following data phase
    always_ff @(posedge clk) begin
        if (!rst_n_i)
            sel_dp <= soc_pkg::SLV_RAM;     // RAM is always ready, safe start
        else if (addr_ph)
            sel_dp <= sel;
    end

    always_comb begin
        case (sel_dp)
            soc_pkg::SLV_RAM: begin
                bus.hrdata = ram.hrdata;
                bus.hready = ram.hready;
            end
            soc_pkg::SLV_GPIO: begin
                bus.hrdata = gpio.hrdata;
                bus.hready = gpio.hready;
            end
            soc_pkg::SLV_PWM: begin
                bus.hrdata = pwm.hrdata;
                bus.hready = pwm.hready;
            end
            default: begin
                bus.hrdata = '0;
                bus.hready = 1'b1;
            end
        endcase
    end

    // routing needs known select bits in every address phase
    a_sel_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        addr_ph |-> !$isunknown(sel));

endmodule : ahb_decoder

// File: ahb_ram_slave.sv
`timescale 1ns/1ps

module ahb_ram_slave #(
    parameter int ram_depth = 1024              // number of 32 bit words
) (
    input  logic    clk,                        // system clock
    input  logic    rst_n_i,                    // sync reset, active low
    ahb_if.slave    bus                         // AHB slave side
);

    localparam int aw = $clog2(ram_depth);      // word index width

    soc_pkg::data_t     mem [ram_depth];        // word array
    logic               addr_ph;                // valid address phase
    logic               wr_r;                   // data phase is a write
    logic [3 : 0]       be_r;                   // byte lanes for the write
    logic [aw-1 : 0]    idx_r;                  // word index for the write
    soc_pkg::data_t     rdata_r;                // read data for data phase

    // lane enables from size and low address bits
    function automatic logic [3 : 0] lane_en(input soc_pkg::hsize_t hsize,
                                             input logic [1 : 0] ofs);
        case (hsize)
            soc_pkg::HSIZE_BYTE: return 4'b0001 << ofs;
            soc_pkg::HSIZE_HALF: return 4'b0011 << {ofs[1], 1'b0};
            default:             return 4'b1111;
        endcase
    endfunction

    assign addr_ph = bus.hsel && (bus.htrans == soc_pkg::HTRANS_NONSEQ) && bus.hready;

    always_ff @(posedge clk) begin
        if (!rst_n_i)
            wr_r <= 1'b0;
        else
            wr_r <= addr_ph && bus.hwrite;
    end

    always_ff @(posedge clk) begin
        if (addr_ph) begin
            be_r  <= lane_en(bus.hsize, bus.haddr[1 : 0]);
            idx_r <= bus.haddr[aw+1 : 2];
        end
    end

    // data phase write, each lane takes its own slice of hwdata
    always_ff @(posedge clk) begin
        if (wr_r) begin
            for (int i = 0; i < 4; i++) begin
                if (be_r[i])
                    mem[idx_r][8*i +: 8] <= bus.hwdata[8*i +: 8];
            end
        end
    end

    // read with address phase haddr, data out one cycle later
    always_ff @(posedge clk) begin
        if (addr_ph && !bus.hwrite)
            rdata_r <= mem[bus.haddr[aw+1 : 2]];
    end

    assign bus.hrdata = rdata_r;
    assign bus.hready = 1'b1;                   // zero wait states

    // the slave window is wider than the RAM, no silent aliasing
    a_idx_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        addr_ph |-> (bus.haddr[soc_pkg::SLV_SEL_LSB-1 : 2] < ram_depth));

endmodule : ahb_ram_slave

// File: ahb_gpio_slave.sv
`timescale 1ns/1ps

module ahb_gpio_slave #(
    parameter int gpio_w = 8                    // GPIO width
) (
    input  logic                clk,            // system clock
    input  logic                rst_n_i,        // sync reset, active low
    ahb_if.slave                bus,            // AHB slave side
    input  logic [gpio_w-1 : 0] gpi_i,          // pin inputs, asynchronous
    output logic [gpio_w-1 : 0] gpo_o,          // output register
    output logic [gpio_w-1 : 0] gpd_o           // direction register
);

    logic [gpio_w-1 : 0]    gpi_s1;             // first sync stage
    logic [gpio_w-1 : 0]    gpi_s2;             // synchronized inputs
    logic                   addr_ph;            // valid address phase
    logic                   wr_r;               // data phase is a write
    logic [3 : 0]           ofs_r;              // register offset for the write
    soc_pkg::data_t         rdata_r;            // read data for data phase
    soc_pkg::data_t         rdata_nxt;          // read mux at address phase

    assign addr_ph = bus.hsel && (bus.htrans == soc_pkg::HTRANS_NONSEQ) && bus.hready;

    always_ff @(posedge clk) begin
        gpi_s1 <= gpi_i;
        gpi_s2 <= gpi_s1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i)
            wr_r <= 1'b0;
        else
            wr_r <= addr_ph && bus.hwrite;
    end

    always_ff @(posedge clk) begin
        if (addr_ph)
            ofs_r <= bus.haddr[3 : 0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            gpo_o <= '0;
            gpd_o <= '0;                        // all pins inputs after reset
        end else if (wr_r) begin
            if (ofs_r == soc_pkg::GPIO_GPO_OFS) gpo_o <= bus.hwdata[gpio_w-1 : 0];
            if (ofs_r == soc_pkg::GPIO_GPD_OFS) gpd_o <= bus.hwdata[gpio_w-1 : 0];
        end
    end

    always_comb begin
        case (bus.haddr[3 : 0])
            soc_pkg::GPIO_GPI_OFS: rdata_nxt = soc_pkg::data_t'(gpi_s2);
            soc_pkg::GPIO_GPO_OFS: rdata_nxt = soc_pkg::data_t'(gpo_o);
            soc_pkg::GPIO_GPD_OFS: rdata_nxt = soc_pkg::data_t'(gpd_o);
            default:               rdata_nxt = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (addr_ph && !bus.hwrite)
            rdata_r <= rdata_nxt;
    end

    assign bus.hrdata = rdata_r;
    assign bus.hready = 1'b1;

endmodule : ahb_gpio_slave

// File: ahb_pwm_slave.sv
`timescale 1ns/1ps

module ahb_pwm_slave #(
    parameter int pwm_width = 8                 // counter and duty width
) (
    input  logic    clk,                        // system clock, also PWM clock
    input  logic    rst_n_i,                    // sync reset, active low
    ahb_if.slave    bus,                        // AHB slave side
    output logic    pwm_o                       // PWM output, registered
);

    logic [pwm_width-1 : 0] duty;               // high cycles per period
    logic [pwm_width-1 : 0] cnt;                // free running period counter
    logic                   addr_ph;            // valid address phase
    logic                   wr_r;               // data phase is a write
    logic [3 : 0]           ofs_r;              // register offset for the write
    soc_pkg::data_t         rdata_r;            // read data for data phase

    assign addr_ph = bus.hsel && (bus.htrans == soc_pkg::HTRANS_NONSEQ) && bus.hready;

    always_ff @(posedge clk) begin
        if (!rst_n_i)
            wr_r <= 1'b0;
        else
            wr_r <= addr_ph && bus.hwrite;
    end

    always_ff @(posedge clk) begin
        if (addr_ph)
            ofs_r <= bus.haddr[3 : 0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i)
            duty <= '0;
        else if (wr_r && (ofs_r == soc_pkg::PWM_DUTY_OFS))
            duty <= bus.hwdata[pwm_width-1 : 0];
    end

    always_ff @(posedge clk) begin
        if (addr_ph && !bus.hwrite)
            rdata_r <= (bus.haddr[3 : 0] == soc_pkg::PWM_DUTY_OFS) ?
                       soc_pkg::data_t'(duty) : '0;
    end

    // wraps every 2^pwm_width cycles, so duty counts are exact per window
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt   <= '0;
            pwm_o <= 1'b0;
        end else begin
            cnt   <= cnt + 1'b1;
            pwm_o <= (cnt < duty);
        end
    end

    assign bus.hrdata = rdata_r;
    assign bus.hready = 1'b1;

endmodule : ahb_pwm_slave

// File: periph_top.sv
`timescale 1ns/1ps

module periph_top #(
    parameter int ram_depth = 1024,             // RAM words
    parameter int gpio_w    = 8,                // GPIO width
    parameter int pwm_width = 8                 // PWM resolution
) (
    input  logic                clk,            // system clock
    input  logic                rst_n_i,        // sync reset, active low
    input  soc_pkg::addr_t      addr_i,         // core address
    input  soc_pkg::data_t      wd_i,           // core write data
    input  logic                we_i,           // core write enable
    input  soc_pkg::size_t      size_i,         // core access size
    input  logic                req_i,          // core request
    output logic                req_ack_o,      // request acknowledge
    output soc_pkg::data_t      rd_o,           // core read data
    input  logic [gpio_w-1 : 0] gpi_i,          // GPIO inputs
    output logic [gpio_w-1 : 0] gpo_o,          // GPIO outputs
    output logic [gpio_w-1 : 0] gpd_o,          // GPIO direction
    output logic                pwm_o           // PWM output
);

    ahb_if bus_m ();                            // bridge to decoder
    ahb_if ram_s ();                            // decoder to RAM
    ahb_if gpio_s ();                           // decoder to GPIO
    ahb_if pwm_s ();                            // decoder to PWM

    ahb_core_bridge bridge_0 (
        .clk        ( clk       ),
        .rst_n_i    ( rst_n_i   ),
        .addr_i     ( addr_i    ),
        .wd_i       ( wd_i      ),
        .we_i       ( we_i      ),
        .size_i     ( size_i    ),
        .req_i      ( req_i     ),
        .req_ack_o  ( req_ack_o ),
        .rd_o       ( rd_o      ),
        .bus        ( bus_m     )
    );

    ahb_decoder decoder_0 (
        .clk        ( clk       ),
        .rst_n_i    ( rst_n_i   ),
        .bus        ( bus_m     ),
        .ram        ( ram_s     ),
        .gpio       ( gpio_s    ),
        .pwm        ( pwm_s     )
    );

    ahb_ram_slave #(.ram_depth(ram_depth)) ram_0 (
        .clk        ( clk       ),
        .rst_n_i    ( rst_n_i   ),
        .bus        ( ram_s     )
    );

    ahb_gpio_slave #(.gpio_w(gpio_w)) gpio_0 (
        .clk        ( clk       ),
        .rst_n_i    ( rst_n_i   ),
        .bus        ( gpio_s    ),
        .gpi_i      ( gpi_i     ),
        .gpo_o      ( gpo_o     ),
        .gpd_o      ( gpd_o     )
    );

    ahb_pwm_slave #(.pwm_width(pwm_width)) pwm_0 (
        .clk        ( clk       ),
        .rst_n_i    ( rst_n_i   ),
        .bus        ( pwm_s     ),
        .pwm_o      ( pwm_o     )
    );

endmodule : periph_top

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
    parameter int gpio_w = 8                    // GPIO width of the DUT
) (
    input  logic                clk,            // testbench clock
    input  logic [2 : 0]        mode_i,         // check kind of the running test
    input  soc_pkg::data_t      exp_i,          // expected value of the running test
    input  int                  tid_i,          // running test number
    input  logic                go_i,           // starts a counting window
    input  logic                req_ack_i,      // DUT req_ack_o
    input  soc_pkg::data_t      rd_i,           // DUT rd_o
    input  logic [gpio_w-1 : 0] gpo_i,          // DUT gpo_o
    input  logic [gpio_w-1 : 0] gpd_i,          // DUT gpd_o
    input  logic                pwm_i,          // DUT pwm_o
    output logic                busy_o,         // a check is still open
    output int                  tests_o,        // finished tests
    output int                  fails_o         // tests with a mismatch
);

    localparam int MODE_RD     = 0;             // compare rd_o at ack
    localparam int MODE_PINS   = 2;             // compare pins one cycle after ack
    localparam int MODE_PWM    = 3;             // count pwm_o highs
    localparam int PWM_WINDOW  = 256;           // one full counter period
    localparam int IDLE_WINDOW = 16;            // quiet cycles after reset

    int                 left;                   // samples still to take
    int                 highs;                  // pwm_o high samples so far
    int                 mode_r;                 // mode of the open check
    int                 tid_r;                  // test number of the open check
    soc_pkg::data_t     exp_r;                  // expected value of the open check
    logic               bad;                    // open test saw a mismatch
    soc_pkg::data_t     pins;                   // gpd_o above gpo_o

    assign pins = soc_pkg::data_t'({gpd_i, gpo_i});

    task automatic compare_value(input string name, input soc_pkg::data_t exp,
                                 input soc_pkg::data_t act);
        if (exp !== act) begin
            $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
            bad = 1'b1;
        end
    endtask

    task automatic close_test();
        tests_o = tests_o + 1;
        if (bad)
            fails_o = fails_o + 1;
        $display("test %0d %s", tid_r, bad ? "failed" : "ok");
        bad    = 1'b0;
        busy_o = 1'b0;
    endtask

    initial begin
        busy_o  = 1'b0;
        tests_o = 0;
        fails_o = 0;
        bad     = 1'b0;
        left    = 0;
        highs   = 0;
    end

    // outputs move on the rising edge, so sample them in mid cycle
    always @(negedge clk) begin
        if (busy_o) begin
            if (mode_r == MODE_PINS) begin
                compare_value("gpd_o,gpo_o", exp_r, pins);
                close_test();
            end else if (mode_r == MODE_PWM) begin
                highs = highs + pwm_i;
                left  = left - 1;
                if (left == 0) begin
                    compare_value("pwm_o high cycles", exp_r, soc_pkg::data_t'(highs));
                    close_test();
                end
            end else begin
                compare_value("req_ack_o", '0, soc_pkg::data_t'(req_ack_i));  // no request made
                compare_value("pwm_o", '0, soc_pkg::data_t'(pwm_i));
                left = left - 1;
                if (left == 0) begin
                    compare_value("gpd_o,gpo_o", exp_r, pins);
                    close_test();
                end
            end
        end else if (go_i) begin
            busy_o = 1'b1;                      // window starts with the next sample
            mode_r = mode_i;
            exp_r  = exp_i;
            tid_r  = tid_i;
            highs  = 0;
            left   = (mode_i == MODE_PWM) ? PWM_WINDOW : IDLE_WINDOW;
        end else if (req_ack_i) begin
            mode_r = mode_i;
            exp_r  = exp_i;
            tid_r  = tid_i;
            if (mode_i == MODE_RD) begin
                compare_value("rd_o", exp_i, rd_i);
                close_test();
            end else if (mode_i == MODE_PINS) begin
                busy_o = 1'b1;                  // registers update at the ack edge
            end else begin
                close_test();
            end
        end
    end

endmodule : tb_checker

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int CLK_PERIOD  = 100;           // ns
    localparam int DRIVE_DELAY = 5;             // ns after the rising edge
    localparam int GPIO_W      = 8;
    localparam int ACK_TIMEOUT = 64;            // cycles to wait for req_ack_o
    localparam int WIN_TIMEOUT = 400;           // cycles to wait for the checker
    localparam int OP_RD       = 0;             // read, compare rd_o
    localparam int OP_WR       = 1;             // write, ack only
    localparam int OP_PWM      = 3;             // count pwm_o highs
    localparam int OP_GPI      = 4;             // new gpi_i value, then read it
    localparam int OP_IDLE     = 5;             // no request, outputs quiet

    logic                   clk;
    logic                   rst_n;
    soc_pkg::addr_t         addr;
    soc_pkg::data_t         wd;
    logic                   we;
    soc_pkg::size_t         size;
    logic                   req;
    logic                   req_ack;
    soc_pkg::data_t         rd;
    logic [GPIO_W-1 : 0]    gpi;
    logic [GPIO_W-1 : 0]    gpo;
    logic [GPIO_W-1 : 0]    gpd;
    logic                   pwm;

    logic [2 : 0]           mode;               // check kind handed to the checker
    soc_pkg::data_t         exp_val;            // expected value handed to the checker
    logic                   go;                 // window start pulse
    int                     tid;                // running test number
    logic                   busy;               // checker still working
    int                     tests;
    int                     fails;

    logic [31 : 0]          rnd_state;          // random generator state
    logic                   aborted;            // run stopped early
    int                     fd;
    int                     nf;                 // fields found on a line
    logic [8*128-1 : 0]     line;               // one text line of the data file
    int                     f_op;
    int                     f_size;
    soc_pkg::data_t         f_addr;
    soc_pkg::data_t         f_data;
    soc_pkg::data_t         f_exp;

    periph_top #(.gpio_w(GPIO_W)) dut_i (
        .clk        ( clk       ),
        .rst_n_i    ( rst_n     ),
        .addr_i     ( addr      ),
        .wd_i       ( wd        ),
        .we_i       ( we        ),
        .size_i     ( size      ),
        .req_i      ( req       ),
        .req_ack_o  ( req_ack   ),
        .rd_o       ( rd        ),
        .gpi_i      ( gpi       ),
        .gpo_o      ( gpo       ),
        .gpd_o      ( gpd       ),
        .pwm_o      ( pwm       )
    );

    tb_checker #(.gpio_w(GPIO_W)) chk_0 (
        .clk        ( clk       ),
        .mode_i     ( mode      ),
        .exp_i      ( exp_val   ),
        .tid_i      ( tid       ),
        .go_i       ( go        ),
        .req_ack_i  ( req_ack   ),
        .rd_i       ( rd        ),
        .gpo_i      ( gpo       ),
        .gpd_i      ( gpd       ),
        .pwm_i      ( pwm       ),
        .busy_o     ( busy      ),
        .tests_o    ( tests     ),
        .fails_o    ( fails     )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31 : 0] next_random(input logic [31 : 0] x);
        logic [31 : 0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // one bus transfer, returns just after the edge that ends the ack cycle
    task automatic bus_op(input soc_pkg::addr_t a, input soc_pkg::data_t d,
                          input logic w, input soc_pkg::size_t sz);
        int n;
        addr = a;
        wd   = d;
        we   = w;
        size = sz;
        req  = 1'b1;
        n    = 0;
        do begin
            @(negedge clk);
            n = n + 1;
        end while (!req_ack && (n < ACK_TIMEOUT));
        if (!req_ack) begin
            $display("test %0d: no req_ack_o within %0d cycles", tid, ACK_TIMEOUT);
            aborted = 1'b1;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        req = 1'b0;                             // request ends with the ack cycle
    endtask

    // returns on a rising edge once the checker has closed the test
    task automatic wait_checker();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n = n + 1;
        end while (busy && (n < WIN_TIMEOUT));
        if (busy) begin
            $display("test %0d: checker did not finish within %0d cycles", tid, WIN_TIMEOUT);
            aborted = 1'b1;
        end
    endtask

    task automatic run_line(input int op, input soc_pkg::addr_t a, input soc_pkg::data_t d,
                            input soc_pkg::size_t sz, input soc_pkg::data_t e);
        #DRIVE_DELAY;
        req = 1'b0;
        tid = tid + 1;
        if (op == OP_GPI) begin
            rnd_state = next_random(rnd_state);
            gpi       = rnd_state[GPIO_W-1 : 0];
            repeat (3) @(posedge clk);          // through the two-flop synchronizer
            #DRIVE_DELAY;
            mode    = 3'(OP_RD);
            exp_val = soc_pkg::data_t'(gpi);    // file column unused here
            bus_op(a, d, 1'b0, sz);
        end else if ((op == OP_PWM) || (op == OP_IDLE)) begin
            mode    = 3'(op);
            exp_val = e;
            go      = 1'b1;
            @(posedge clk);
            #DRIVE_DELAY go = 1'b0;
        end else begin
            mode    = 3'(op);
            exp_val = e;
            bus_op(a, d, op != OP_RD, sz);
        end
        if (!aborted)
            wait_checker();
    endtask

    initial begin
        rst_n     = 1'b0;
        addr      = '0;
        wd        = '0;
        we        = 1'b0;
        size      = '0;
        req       = 1'b0;
        gpi       = '0;
        mode      = 3'(OP_WR);
        exp_val   = '0;
        go        = 1'b0;
        tid       = 0;
        rnd_state = 32'hc81c;
        aborted   = 1'b0;
        fd = $fopen("periph_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open periph_testdata.txt");
            aborted = 1'b1;
        end
        repeat (3) @(posedge clk);
        #DRIVE_DELAY rst_n = 1'b1;
        @(posedge clk);
        while (!aborted && !$feof(fd)) begin
            line = '0;
            nf   = $fgets(line, fd);
            nf   = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_data, f_size, f_exp);
            if (nf == 5)                        // comment and blank lines give fewer
                run_line(f_op, f_addr, f_data, soc_pkg::size_t'(f_size), f_exp);
        end
        #DRIVE_DELAY req = 1'b0;
        $display("tests %0d, failed %0d", tests, fails);
        if (aborted || (fails != 0) || (tests == 0))
            $display("*** FAILED ***");
        else
            $display("*** PASSED ***");
        $finish;
    end

endmodule : tb_top

// File: periph_testdata.txt
# op addr data size expected, all hex; op 0 read, 1 write, 2 write and check {gpd,gpo}
# op 3 pwm high count window, 4 gpi read (expected column unused), 5 idle after reset
5 00000000 00000000 0 00000000
# RAM words
1 00000000 11223344 2 00000000
1 00000ffc deadbeef 2 00000000
1 00000ffc cafef00d 2 00000000
0 00000000 00000000 2 11223344
0 00000ffc 00000000 2 cafef00d
# RAM byte and halfword lanes on word 0
1 00000001 aabbccdd 0 00000000
1 00000002 99887766 1 00000000
0 00000000 00000000 2 9988cc44
1 00000003 0f0e0d0c 0 00000000
1 00000000 12345678 1 00000000
0 00000000 00000000 2 0f885678
# GPIO
2 00010004 0000005a 2 0000005a
2 00010008 000000f0 2 0000f05a
0 00010004 00000000 2 0000005a
0 00010008 00000000 2 000000f0
4 00010000 00000000 2 00000000
4 00010000 00000000 2 00000000
# PWM duty 0, 64, 255
1 00020000 00000000 2 00000000
3 00000000 00000000 0 00000000
1 00020000 00000040 2 00000000
3 00000000 00000000 0 00000040
0 00020000 00000000 2 00000040
1 00020000 000000ff 2 00000000
3 00000000 00000000 0 000000ff
0 00020000 00000000 2 000000ff
# unmapped window
0 00030000 00000000 2 00000000
2 0003000c ffffffff 2 0000f05a
0 00020000 00000000 2 000000ff
0 00000000 00000000 2 0f885678

// File: src.f
soc_pkg.sv
ahb_if.sv
ahb_core_bridge.sv
ahb_decoder.sv
ahb_ram_slave.sv
ahb_gpio_slave.sv
ahb_pwm_slave.sv
periph_top.sv
tb_checker.sv
tb_top.sv
